// ==== Makefile ====
# Verilator build and run of the sound generator testbench

VERILATOR ?= verilator
TOP       ?= ay_psg_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
rtl/ay_pkg.sv
rtl/ay_regs.sv
rtl/ay_tone.sv
rtl/ay_noise.sv
rtl/ay_envelope.sv
rtl/ay_mixer.sv
rtl/ay_psg.sv
verification/ay_psg_tb.sv

// ==== rtl/ay_envelope.sv ====
// Envelope generator, steps a four-bit level in runs of 16 as set by the shape bits
module ay_envelope (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ay_clk,
    input  logic [ay_pkg::env_w-1:0]   env_period,
    input  logic [3:0]                 env_shape,
    input  logic                       env_restart,
    output logic [ay_pkg::level_w-1:0] env_level
);

    localparam logic [ay_pkg::env_w-1:0] cnt_one = 1;
    localparam logic [ay_pkg::level_w-1:0] lvl_one = 1;

    ay_pkg::env_state_e        state;
    logic [ay_pkg::env_w-1:0]  env_cnt;
    logic [3:0]                step_cnt;
    logic                      attack;

    // Shape bit names as in the original data sheet
    logic shape_cont;
    logic shape_att;
    logic shape_alt;
    logic shape_hold;

    assign shape_cont = env_shape[3];
    assign shape_att  = env_shape[2];
    assign shape_alt  = env_shape[1];
    assign shape_hold = env_shape[0];

    // **************************************************
    // Step control
    // **************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ay_pkg::env_run;
            env_cnt   <= '0;
            step_cnt  <= '0;
            attack    <= 1'b0;
            env_level <= '0;
        end else if (env_restart) begin
            // A shape write starts a fresh run from the bottom or the top
            state     <= ay_pkg::env_run;
            env_cnt   <= '0;
            step_cnt  <= '0;
            attack    <= shape_att;
            env_level <= shape_att ? '0 : '1;
        end else if (ay_clk && state == ay_pkg::env_run) begin
            if (env_cnt == '0) begin
                env_cnt <= env_period;
                if (step_cnt == 4'd15) begin
                    // Sixteenth step closes the run
                    step_cnt <= '0;
                    if (!shape_cont) begin
                        env_level <= '0;
                        state <= ay_pkg::env_hold;
                    end else if (shape_hold) begin
                        if (shape_alt) begin
                            env_level <= ~env_level;
                        end
                        state <= ay_pkg::env_hold;
                    end else if (shape_alt) begin
                        // Level stays put and the next run heads the other way
                        attack <= ~attack;
                    end else begin
                        env_level <= attack ? '0 : '1;
                    end
                end else begin
                    step_cnt <= step_cnt + 4'd1;
                    env_level <= attack ? env_level + lvl_one : env_level - lvl_one;
                end
            end else begin
                env_cnt <= env_cnt - cnt_one;
            end
        end
    end

    // Once held, only a new shape write moves the level again
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        (state == ay_pkg::env_hold && !env_restart) |=> $stable(env_level));

endmodule

// ==== rtl/ay_mixer.sv ====
// Mixer, gates each channel by tone and noise and sums the three levels into the audio word
module ay_mixer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        tone_a,
    input  logic                        tone_b,
    input  logic                        tone_c,
    input  logic                        noise,
    input  logic [2:0]                  tone_off,
    input  logic [2:0]                  noise_off,
    input  logic [ay_pkg::level_w:0]    amp_a,
    input  logic [ay_pkg::level_w:0]    amp_b,
    input  logic [ay_pkg::level_w:0]    amp_c,
    input  logic [ay_pkg::level_w-1:0]  env_level,
    output logic [ay_pkg::audio_w-1:0]  audio
);

    localparam int pad_w = ay_pkg::audio_w - ay_pkg::level_w;

    // Level one channel adds to the sum, widened to the audio width
    function automatic logic [ay_pkg::audio_w-1:0] chan_level(
        input logic                        tone,
        input logic                        noise_bit,
        input logic                        t_off,
        input logic                        n_off,
        input logic [ay_pkg::level_w:0]    amp,
        input logic [ay_pkg::level_w-1:0]  env_lvl
    );
        logic                        active;
        logic [ay_pkg::level_w-1:0]  lvl;
        // A muted source counts as always high
        active = (tone || t_off) && (noise_bit || n_off);
        // Top bit of the amplitude selects the envelope
        lvl = amp[ay_pkg::level_w] ? env_lvl : amp[ay_pkg::level_w-1:0];
        return active ? {{pad_w{1'b0}}, lvl} : '0;
    endfunction

    logic [ay_pkg::audio_w-1:0] lvl_a;
    logic [ay_pkg::audio_w-1:0] lvl_b;
    logic [ay_pkg::audio_w-1:0] lvl_c;

    assign lvl_a = chan_level(tone_a, noise, tone_off[0], noise_off[0], amp_a, env_level);
    assign lvl_b = chan_level(tone_b, noise, tone_off[1], noise_off[1], amp_b, env_level);
    assign lvl_c = chan_level(tone_c, noise, tone_off[2], noise_off[2], amp_c, env_level);

    // **************************************************
    // Output register
    // **************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            audio <= '0;
        end else begin
            audio <= lvl_a + lvl_b + lvl_c;
        end
    end

    // Three full-scale channels are the ceiling, the sum must not wrap
    audio_range: assert property (@(posedge clk) disable iff (reset) audio <= 6'd45);

endmodule

// ==== rtl/ay_noise.sv ====
// Noise generator shared by all channels, a period counter clocking a 17-bit LFSR
module ay_noise (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ay_clk,
    input  logic [ay_pkg::noise_w-1:0]  noise_period,
    output logic                        noise
);

    localparam logic [ay_pkg::noise_w-1:0] cnt_one = 1;

    logic [ay_pkg::noise_w-1:0] noise_cnt;
    logic [16:0]                lfsr;

    // **************************************************
    // Period counter and shift register
    // **************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            noise_cnt <= '0;
            // Seed of 1 keeps the register out of the all-zero lock-up state
            lfsr <= 17'd1;
        end else if (ay_clk) begin
            if (noise_cnt == '0) begin
                noise_cnt <= noise_period;
                // Shift right, feedback from taps 0 and 3 enters at the top
                lfsr <= {lfsr[0] ^ lfsr[3], lfsr[16:1]};
            end else begin
                noise_cnt <= noise_cnt - cnt_one;
            end
        end
    end

    // Output is the bit that was just shifted out of reach
    assign noise = lfsr[0];

    // Feedback must never collapse the register to zero
    lfsr_live: assert property (@(posedge clk) disable iff (reset) lfsr != '0);

endmodule

// ==== rtl/ay_pkg.sv ====
// Shared widths, register addresses and envelope states for the sound generator, used by scoped name
package ay_pkg;

    // **************************************************
    // Field widths
    // **************************************************

    // Tone period, twelve bits split over a low byte and a high nibble
    localparam int tone_w = 12;

    // Noise period, five bits
    localparam int noise_w = 5;

    // Envelope period, a full sixteen bit word over two bytes
    localparam int env_w = 16;

    // Amplitude of one channel, the envelope level uses the same width
    localparam int level_w = 4;

    // Three channels of at most 15 sum to 45, which needs six bits
    localparam int audio_w = 6;

    // **************************************************
    // Register map
    // **************************************************

    // Addresses 14 and 15 are the I/O ports of the original chip and are not decoded
    typedef enum logic [3:0] {
        tone_a_lo    = 4'd0,
        tone_a_hi    = 4'd1,
        tone_b_lo    = 4'd2,
        tone_b_hi    = 4'd3,
        tone_c_lo    = 4'd4,
        tone_c_hi    = 4'd5,
        noise_period = 4'd6,
        mixer_ctl    = 4'd7,
        amp_a        = 4'd8,
        amp_b        = 4'd9,
        amp_c        = 4'd10,
        env_lo       = 4'd11,
        env_hi       = 4'd12,
        env_shape    = 4'd13
    } ay_reg_e;

    // Envelope either steps through runs or sits on a fixed level
    typedef enum logic {
        env_run  = 1'b0,
        env_hold = 1'b1
    } env_state_e;

endpackage

// ==== rtl/ay_psg.sv ====
// Top level of the three-channel sound generator, host writes in and a linear audio word out
module ay_psg #(
    parameter int CLK_DIV = 8
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wr,
    input  logic [3:0]                  addr,
    input  logic [7:0]                  data,
    output logic [ay_pkg::audio_w-1:0]  audio
);

    logic                        ay_clk;
    logic [ay_pkg::tone_w-1:0]   period_a;
    logic [ay_pkg::tone_w-1:0]   period_b;
    logic [ay_pkg::tone_w-1:0]   period_c;
    logic [ay_pkg::noise_w-1:0]  noise_period;
    logic [ay_pkg::env_w-1:0]    env_period;
    logic [3:0]                  env_shape;
    logic                        env_restart;
    logic [2:0]                  tone_off;
    logic [2:0]                  noise_off;
    logic [ay_pkg::level_w:0]    amp_a;
    logic [ay_pkg::level_w:0]    amp_b;
    logic [ay_pkg::level_w:0]    amp_c;
    logic                        tone_a;
    logic                        tone_b;
    logic                        tone_c;
    logic                        noise;
    logic [ay_pkg::level_w-1:0]  env_level;

    // **************************************************
    // Control block
    // **************************************************

    ay_regs #(.CLK_DIV(CLK_DIV)) ay_regs_inst (.*);

    // **************************************************
    // Generators
    // **************************************************

    // One tone counter per channel
    ay_tone tone_a_inst (.clk, .reset, .ay_clk, .period(period_a), .out(tone_a));
    ay_tone tone_b_inst (.clk, .reset, .ay_clk, .period(period_b), .out(tone_b));
    ay_tone tone_c_inst (.clk, .reset, .ay_clk, .period(period_c), .out(tone_c));

    ay_noise ay_noise_inst (.clk, .reset, .ay_clk, .noise_period, .noise);

    ay_envelope ay_envelope_inst (.clk, .reset, .ay_clk, .env_period, .env_shape,
                                  .env_restart, .env_level);

    // Gating and sum into the registered output
    ay_mixer ay_mixer_inst (.*);

endmodule

// ==== rtl/ay_regs.sv ====
// Register file of the sound generator, takes host writes and makes the chip-clock tick
module ay_regs #(
    parameter int CLK_DIV = 8
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wr,
    input  logic [3:0]                  addr,
    input  logic [7:0]                  data,
    output logic                        ay_clk,
    output logic [ay_pkg::tone_w-1:0]   period_a,
    output logic [ay_pkg::tone_w-1:0]   period_b,
    output logic [ay_pkg::tone_w-1:0]   period_c,
    output logic [ay_pkg::noise_w-1:0]  noise_period,
    output logic [ay_pkg::env_w-1:0]    env_period,
    output logic [3:0]                  env_shape,
    output logic                        env_restart,
    output logic [2:0]                  tone_off,
    output logic [2:0]                  noise_off,
    output logic [ay_pkg::level_w:0]    amp_a,
    output logic [ay_pkg::level_w:0]    amp_b,
    output logic [ay_pkg::level_w:0]    amp_c
);

    // **************************************************
    // Chip-clock prescaler
    // **************************************************

    localparam int pre_w = $clog2(CLK_DIV);
    localparam logic [pre_w-1:0] pre_last = pre_w'(CLK_DIV - 1);
    localparam logic [pre_w-1:0] pre_one = 1;

    logic [pre_w-1:0] prescaler;

    // Counts 0 up to CLK_DIV-1 and wraps, the tick sits on the last count
    always_ff @(posedge clk) begin
        if (reset) begin
            prescaler <= '0;
        end else if (prescaler == pre_last) begin
            prescaler <= '0;
        end else begin
            prescaler <= prescaler + pre_one;
        end
    end

    // One clk cycle wide strobe, all generators advance on it
    assign ay_clk = (prescaler == pre_last);

    // **************************************************
    // Write decode
    // **************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            period_a     <= '0;
            period_b     <= '0;
            period_c     <= '0;
            noise_period <= '0;
            env_period   <= '0;
            env_shape    <= '0;
            env_restart  <= 1'b0;
            tone_off     <= '0;
            noise_off    <= '0;
            amp_a        <= '0;
            amp_b        <= '0;
            amp_c        <= '0;
        end else begin
            // The envelope restarts in the cycle after its shape is written
            env_restart <= wr && (addr == ay_pkg::env_shape);
            if (wr) begin
                case (ay_pkg::ay_reg_e'(addr))
                    ay_pkg::tone_a_lo:    period_a[7:0]   <= data;
                    ay_pkg::tone_a_hi:    period_a[11:8]  <= data[3:0];
                    ay_pkg::tone_b_lo:    period_b[7:0]   <= data;
                    ay_pkg::tone_b_hi:    period_b[11:8]  <= data[3:0];
                    ay_pkg::tone_c_lo:    period_c[7:0]   <= data;
                    ay_pkg::tone_c_hi:    period_c[11:8]  <= data[3:0];
                    ay_pkg::noise_period: noise_period    <= data[4:0];
                    ay_pkg::mixer_ctl: begin
                        // Low three bits mute tones, the next three mute noise
                        tone_off  <= data[2:0];
                        noise_off <= data[5:3];
                    end
                    ay_pkg::amp_a:        amp_a           <= data[4:0];
                    ay_pkg::amp_b:        amp_b           <= data[4:0];
                    ay_pkg::amp_c:        amp_c           <= data[4:0];
                    ay_pkg::env_lo:       env_period[7:0] <= data;
                    ay_pkg::env_hi:       env_period[15:8] <= data;
                    ay_pkg::env_shape:    env_shape       <= data[3:0];
                    // Port registers 14 and 15 are dropped
                    default: ;
                endcase
            end
        end
    end

    // A tick never lasts longer than one cycle, whatever CLK_DIV is set to
    tick_single: assert property (@(posedge clk) disable iff (reset) ay_clk |=> !ay_clk);

endmodule

// ==== rtl/ay_tone.sv ====
// Square-wave tone generator for one channel, toggles its output every half period
module ay_tone (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ay_clk,
    input  logic [ay_pkg::tone_w-1:0]  period,
    output logic                       out
);

    localparam logic [ay_pkg::tone_w-1:0] cnt_one = 1;

    logic [ay_pkg::tone_w-1:0] tone_cnt;
    logic [ay_pkg::tone_w-1:0] tone_cnt_next;
    logic                      out_next;

    // Next state only moves on a tick
    always_comb begin
        tone_cnt_next = tone_cnt;
        out_next = out;
        if (ay_clk) begin
            if (tone_cnt == '0) begin
                // Half the period per half wave, periods 0 and 1 flip every tick
                tone_cnt_next = period >> 1;
                out_next = ~out;
            end else begin
                tone_cnt_next = tone_cnt - cnt_one;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tone_cnt <= '0;
            out <= 1'b0;
        end else begin
            tone_cnt <= tone_cnt_next;
            out <= out_next;
        end
    end

endmodule

// ==== verification/ay_psg_tb.sv ====
// Self-checking testbench for the sound generator, runs a cycle model next to the DUT
module ay_psg_tb;

    localparam int CLK_DIV = 8;

    // Test lengths in chip-clock ticks, the watchdog budget follows from them
    localparam int idle_ticks = 5;
    localparam int tone_ticks = 20;
    localparam int mix_ticks = 250;
    localparam int noise_ticks = 300;
    localparam int env_ticks = 110;
    localparam int total_ticks = 3 * idle_ticks + 3 * tone_ticks + 2 * mix_ticks
                               + 2 * noise_ticks + 8 * env_ticks + 20;
    localparam int limit_cycles = total_ticks * CLK_DIV + 1000;

    // Envelope shapes exercised, each restarts the envelope when written
    localparam logic [7:0] shape_list [7] = '{8'd0, 8'd8, 8'd10, 8'd11, 8'd12, 8'd13, 8'd14};

    logic       clk;
    logic       reset;
    logic       wr;
    logic [3:0] addr;
    logic [7:0] data;
    logic [5:0] audio;
    int         seed = 49;

    ay_psg #(.CLK_DIV(CLK_DIV)) ay_psg_inst (.clk, .reset, .wr, .addr, .data, .audio);

    // **************************************************
    // Reference model state
    // **************************************************

    int                  m_pre;
    logic [11:0]         m_period [3];
    logic [11:0]         m_tcnt [3];
    logic                m_tone [3];
    logic [4:0]          m_amp [3];
    logic [2:0]          m_toff;
    logic [2:0]          m_noff;
    logic [4:0]          m_nper;
    logic [4:0]          m_ncnt;
    logic [16:0]         m_lfsr;
    logic [15:0]         m_eper;
    logic [15:0]         m_ecnt;
    logic [3:0]          m_shape;
    logic                m_restart;
    ay_pkg::env_state_e  m_state;
    logic [3:0]          m_step;
    logic                m_attack;
    logic [3:0]          m_level;
    logic [5:0]          exp_audio;
    logic                model_valid;

    // Advances the model by one clk edge and returns the audio word after that edge
    function automatic logic [5:0] model_step(input logic rst, input logic w,
                                              input logic [3:0] a, input logic [7:0] d);
        logic       tick;
        logic [5:0] sum;
        logic [3:0] lvl;
        int         ch;
        if (rst) begin
            m_pre = 0;
            for (ch = 0; ch < 3; ch++) begin
                m_period[ch] = '0;
                m_tcnt[ch] = '0;
                m_tone[ch] = 1'b0;
                m_amp[ch] = '0;
            end
            m_toff = '0;
            m_noff = '0;
            m_nper = '0;
            m_ncnt = '0;
            m_lfsr = 17'd1;
            m_eper = '0;
            m_ecnt = '0;
            m_shape = '0;
            m_restart = 1'b0;
            m_state = ay_pkg::env_run;
            m_step = '0;
            m_attack = 1'b0;
            m_level = '0;
            return '0;
        end
        tick = (m_pre == CLK_DIV - 1);
        // Mixer sees the generator outputs as they stand before this edge
        sum = '0;
        for (ch = 0; ch < 3; ch++) begin
            lvl = m_amp[ch][4] ? m_level : m_amp[ch][3:0];
            if ((m_tone[ch] || m_toff[ch]) && (m_lfsr[0] || m_noff[ch])) begin
                sum = sum + 6'(lvl);
            end
        end
        // Envelope, a restart wins over a tick
        if (m_restart) begin
            m_state = ay_pkg::env_run;
            m_ecnt = '0;
            m_step = '0;
            m_attack = m_shape[2];
            m_level = m_shape[2] ? 4'd0 : 4'd15;
        end else if (tick && m_state == ay_pkg::env_run) begin
            if (m_ecnt == '0) begin
                m_ecnt = m_eper;
                if (m_step == 4'd15) begin
                    // End of a run of 16 steps
                    m_step = '0;
                    if (!m_shape[3]) begin
                        m_level = '0;
                        m_state = ay_pkg::env_hold;
                    end else if (m_shape[0]) begin
                        if (m_shape[1]) begin
                            m_level = ~m_level;
                        end
                        m_state = ay_pkg::env_hold;
                    end else if (m_shape[1]) begin
                        m_attack = !m_attack;
                    end else begin
                        m_level = m_attack ? 4'd0 : 4'd15;
                    end
                end else begin
                    m_step = m_step + 4'd1;
                    m_level = m_attack ? m_level + 4'd1 : m_level - 4'd1;
                end
            end else begin
                m_ecnt = m_ecnt - 16'd1;
            end
        end
        // Tones reload half the period and flip on count-out
        for (ch = 0; ch < 3; ch++) begin
            if (tick) begin
                if (m_tcnt[ch] == '0) begin
                    m_tcnt[ch] = m_period[ch] >> 1;
                    m_tone[ch] = !m_tone[ch];
                end else begin
                    m_tcnt[ch] = m_tcnt[ch] - 12'd1;
                end
            end
        end
        if (tick) begin
            if (m_ncnt == '0) begin
                m_ncnt = m_nper;
                m_lfsr = {m_lfsr[0] ^ m_lfsr[3], m_lfsr[16:1]};
            end else begin
                m_ncnt = m_ncnt - 5'd1;
            end
        end
        m_pre = tick ? 0 : m_pre + 1;
        // Register writes land last so every block above used the old values
        m_restart = w && (a == ay_pkg::env_shape);
        if (w) begin
            case (ay_pkg::ay_reg_e'(a))
                ay_pkg::tone_a_lo:    m_period[0][7:0] = d;
                ay_pkg::tone_a_hi:    m_period[0][11:8] = d[3:0];
                ay_pkg::tone_b_lo:    m_period[1][7:0] = d;
                ay_pkg::tone_b_hi:    m_period[1][11:8] = d[3:0];
                ay_pkg::tone_c_lo:    m_period[2][7:0] = d;
                ay_pkg::tone_c_hi:    m_period[2][11:8] = d[3:0];
                ay_pkg::noise_period: m_nper = d[4:0];
                ay_pkg::mixer_ctl: begin
                    m_toff = d[2:0];
                    m_noff = d[5:3];
                end
                ay_pkg::amp_a:        m_amp[0] = d[4:0];
                ay_pkg::amp_b:        m_amp[1] = d[4:0];
                ay_pkg::amp_c:        m_amp[2] = d[4:0];
                ay_pkg::env_lo:       m_eper[7:0] = d;
                ay_pkg::env_hi:       m_eper[15:8] = d;
                ay_pkg::env_shape:    m_shape = d[3:0];
                default: ;
            endcase
        end
        return sum;
    endfunction

    // **************************************************
    // Checking and stimulus helpers
    // **************************************************

    task automatic check_value(input logic [5:0] got, input logic [5:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("Fail at time %0t: %s, got %0d, expected %0d", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "Audio mismatch against the model");
        end
    endtask

    // One write strobe, held for a single clk cycle
    task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
        @(posedge clk);
        wr <= 1'b1;
        addr <= a;
        data <= d;
        @(posedge clk);
        wr <= 1'b0;
    endtask

    task automatic wait_ticks(input int n);
        repeat (n * CLK_DIV) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Inputs and audio are both stable at the falling edge
    initial begin
        model_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (model_valid) begin
                check_value(audio, exp_audio, "audio differs from the reference model");
            end
            exp_audio = model_step(reset, wr, addr, data);
            // Comparison starts once the model has taken a reset step
            if (reset === 1'b1) begin
                model_valid = 1'b1;
            end
        end
    end

    initial begin
        #(limit_cycles * 10);
        $display("Watchdog timeout, the tests did not finish in the expected time");
        $display("=== FAIL ===");
        $fatal(1, "Run stopped by the watchdog");
    end

    // **************************************************
    // Test sequence
    // **************************************************

    initial begin
        int i;
        reset = 1'b1;
        wr = 1'b0;
        addr = '0;
        data = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // Silence after reset, every amplitude is still 0
        wait_ticks(idle_ticks);
        // Channel A alone, tone only, fixed level, periods 0, 1 and 5
        write_reg(ay_pkg::mixer_ctl, 8'h3E);
        write_reg(ay_pkg::amp_a, 8'd10);
        write_reg(ay_pkg::tone_a_lo, 8'd0);
        wait_ticks(tone_ticks);
        write_reg(ay_pkg::tone_a_lo, 8'd1);
        wait_ticks(tone_ticks);
        write_reg(ay_pkg::tone_a_lo, 8'd5);
        wait_ticks(tone_ticks);
        // All three tones with random periods and levels
        write_reg(ay_pkg::mixer_ctl, 8'h38);
        write_reg(ay_pkg::tone_a_lo, 8'($random(seed)));
        write_reg(ay_pkg::tone_b_lo, 8'($random(seed)));
        write_reg(ay_pkg::tone_c_lo, 8'($random(seed)));
        write_reg(ay_pkg::amp_a, 8'($random(seed)) & 8'h0F);
        write_reg(ay_pkg::amp_b, 8'($random(seed)) & 8'h0F);
        write_reg(ay_pkg::amp_c, 8'($random(seed)) & 8'h0F);
        wait_ticks(mix_ticks);
        // Period bytes rewritten while the tones are running
        write_reg(ay_pkg::tone_a_lo, 8'($random(seed)));
        write_reg(ay_pkg::tone_b_hi, 8'($random(seed)) & 8'h01);
        write_reg(ay_pkg::tone_c_lo, 8'($random(seed)));
        wait_ticks(mix_ticks);
        // Noise only on channel A, then tone and noise together
        write_reg(ay_pkg::noise_period, 8'($random(seed)) & 8'h0F);
        write_reg(ay_pkg::mixer_ctl, 8'h37);
        wait_ticks(noise_ticks);
        write_reg(ay_pkg::mixer_ctl, 8'h36);
        wait_ticks(noise_ticks);
        // Envelope on channel A with every source muted
        write_reg(ay_pkg::mixer_ctl, 8'h3F);
        write_reg(ay_pkg::amp_b, 8'd0);
        write_reg(ay_pkg::amp_c, 8'd0);
        write_reg(ay_pkg::amp_a, 8'h10);
        write_reg(ay_pkg::env_lo, 8'd2);
        write_reg(ay_pkg::env_hi, 8'd0);
        for (i = 0; i < 7; i++) begin
            write_reg(ay_pkg::env_shape, shape_list[i]);
            wait_ticks(env_ticks);
        end
        // Same shape written again in the middle of a run
        write_reg(ay_pkg::env_shape, 8'd14);
        wait_ticks(20);
        write_reg(ay_pkg::env_shape, 8'd14);
        wait_ticks(env_ticks);
        // Port addresses are not decoded, nothing may move
        write_reg(4'd14, 8'($random(seed)));
        write_reg(4'd15, 8'($random(seed)));
        wait_ticks(idle_ticks);
        wait_ticks(idle_ticks);
        $display("=== PASS ===");
        $finish;
    end

endmodule
